/* build.f */
verilog/atl_pkg.sv
verilog/atl_ingress_buffer.sv
verilog/atl_conv2to1.sv
verilog/atl_packet_merge.sv
verilog/atl_narrow_path.sv
verification/tb_clock_gen.sv
verification/tb_atl_narrow_path.sv

/* run_sim.sh */
#!/bin/sh
# build the narrowing path testbench with Verilator and run it
# exit status is the simulator's, nonzero on any failing run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_atl_narrow_path -f build.f -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation did not complete cleanly"; exit 1; }

/* verification/tb_atl_narrow_path.sv */
// tb_atl_narrow_path
// random wide packets in, random back-pressure out, per-lane queues of
// expected narrow words, concurrent assertions check the output stream
`default_nettype none

module tb_atl_narrow_path;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SEED      = 32'hb9d1d849;
   localparam int N_PKTS    = 60;
   localparam int MAX_WIDE  = 6;                      // wide words per packet
   localparam int CLK_NS    = 40;
   localparam int EXP_W     = atl_pkg::NARROW_W + atl_pkg::NARROW_MTY_W + atl_pkg::ADR_W + 3;
   // every narrow word may wait on back-pressure, plus arbitration per packet
   localparam int PKT_CYCLES      = 2 * MAX_WIDE * 4 + 16;
   localparam int WATCHDOG_CYCLES = 2 * N_PKTS * PKT_CYCLES + 16;

   wire                   clk;
   wire                   reset_n;
   logic                  in_wrena, in_sop, in_eop, in_err, out_rdena;
   atl_pkg::wide_dat_t    in_dat;
   atl_pkg::wide_mty_t    in_mty;
   atl_pkg::adr_t         in_adr;
   wire                   in_rdena, out_wrena, out_sop, out_eop, out_err;
   atl_pkg::narrow_dat_t  out_dat;
   atl_pkg::narrow_mty_t  out_mty;
   atl_pkg::adr_t         out_adr;

   integer                pkt_seed;
   integer                bp_seed;
   logic                  traffic_started;
   logic [EXP_W:0]        exp_q [atl_pkg::NUM_LANES][$];  // msb marks a top half
   logic                  chk_vld, chk_empty;   // output word seen last cycle
   logic [EXP_W-1:0]      chk_got, chk_exp;
   logic                  in_pkt;               // between sop and eop
   atl_pkg::adr_t         pkt_adr;
   logic [atl_pkg::NUM_LANES-1:0] served;
   int                    top_ends, bottom_ends;

   tb_clock_gen u_clk (.clk(clk), .reset_n(reset_n));

   atl_narrow_path uut (
      .clk(clk), .reset_n(reset_n),
      .in_wrena(in_wrena), .in_dat(in_dat), .in_mty(in_mty), .in_adr(in_adr),
      .in_sop(in_sop), .in_eop(in_eop), .in_err(in_err), .in_rdena(in_rdena),
      .out_rdena(out_rdena), .out_wrena(out_wrena),
      .out_dat(out_dat), .out_mty(out_mty), .out_adr(out_adr),
      .out_sop(out_sop), .out_eop(out_eop), .out_err(out_err)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   function automatic logic all_drained();
      for (int l = 0; l < atl_pkg::NUM_LANES; l++) begin
         if (exp_q[l].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   // one wide word as the narrow words it must become
   task automatic expect_halves(input atl_pkg::wide_dat_t dat, input atl_pkg::wide_mty_t mty,
                                input atl_pkg::adr_t adr, input logic sop, eop, err);
      atl_pkg::lane_t lane;
      logic           top_only;
      lane     = adr[atl_pkg::LANE_W-1:0];
      top_only = eop && mty[atl_pkg::WIDE_MTY_W-1];       // mostly empty last word
      exp_q[lane].push_back({1'b1, dat[63:32], top_only ? mty[1:0] : 2'b00,
                             adr, sop, top_only, err});
      if (!top_only) begin
         exp_q[lane].push_back({1'b0, dat[31:0], mty[1:0], adr, 1'b0, eop, err});
      end
   endtask

   // waits for a free slot, then drives one word for the next edge
   task automatic send_word(input atl_pkg::wide_dat_t dat, input atl_pkg::wide_mty_t mty,
                            input atl_pkg::adr_t adr, input logic sop, eop, err);
      @(posedge clk);
      while (!in_rdena) begin
         in_wrena <= 1'b0;
         @(posedge clk);
      end
      in_wrena <= 1'b1;
      in_dat   <= dat;
      in_mty   <= mty;
      in_adr   <= adr;
      in_sop   <= sop;
      in_eop   <= eop;
      in_err   <= err;
      traffic_started <= 1'b1;
      expect_halves(dat, mty, adr, sop, eop, err);
   endtask

   // ---------------------------------------------------------------------
   // stimulus and end of run
   // ---------------------------------------------------------------------
   initial begin : stimulus
      int                 len;
      atl_pkg::adr_t      adr;
      atl_pkg::wide_dat_t dat;
      atl_pkg::wide_mty_t mty;
      logic               eop, err;
      pkt_seed = SEED;
      traffic_started = 1'b0;
      in_wrena = 1'b0;
      in_dat   = '0;
      in_mty   = '0;
      in_adr   = '0;
      in_sop   = 1'b0;
      in_eop   = 1'b0;
      in_err   = 1'b0;
      wait (reset_n);
      repeat (4) @(posedge clk);                         // quiet window after reset
      for (int p = 0; p < N_PKTS; p++) begin
         len = 1 + int'($unsigned($random(pkt_seed)) % MAX_WIDE);
         adr = atl_pkg::adr_t'($random(pkt_seed));
         for (int w = 0; w < len; w++) begin
            dat[63:32] = $random(pkt_seed);
            dat[31:0]  = $random(pkt_seed);
            eop = (w == len - 1);
            mty = eop ? atl_pkg::wide_mty_t'($random(pkt_seed)) : '0;
            err = eop && (($random(pkt_seed) & 7) == 0);  // rare, only carried
            send_word(dat, mty, adr, w == 0, eop, err);
         end
         if (($random(pkt_seed) & 3) == 0) begin
            @(posedge clk);
            in_wrena <= 1'b0;                             // idle gap
         end
      end
      @(posedge clk);
      in_wrena <= 1'b0;
      while (!all_drained()) @(posedge clk);
      repeat (20) @(posedge clk);                         // room for strays or repeats
      if (served != '1 || top_ends == 0 || bottom_ends == 0 || !all_drained())
         stop_on_error($sformatf("incomplete run: lanes served %b, top-half ends %0d, %s %0d",
                                 served, top_ends, "bottom-half ends", bottom_ends));
      else begin
         $display("Finished with no errors");
         $finish;
      end
   end

   initial begin : back_pressure
      bp_seed   = ~SEED;
      out_rdena = 1'b0;
      wait (reset_n);
      forever begin
         @(posedge clk);
         out_rdena <= ($random(bp_seed) & 3) != 0;        // high three quarters
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_NS);
      stop_on_error($sformatf("timeout: the %0d packets did not drain in %0d cycles",
                              N_PKTS, WATCHDOG_CYCLES));
   end

   // ---------------------------------------------------------------------
   // output monitor, pops the lane queue for every output word
   // ---------------------------------------------------------------------
   always @(posedge clk or negedge reset_n) begin : monitor
      atl_pkg::lane_t lane;
      logic [EXP_W:0] head;
      if (!reset_n) begin
         chk_vld     <= 1'b0;
         chk_empty   <= 1'b0;
         chk_got     <= '0;
         chk_exp     <= '0;
         in_pkt      <= 1'b0;
         pkt_adr     <= '0;
         served      <= '0;
         top_ends    <= 0;
         bottom_ends <= 0;
      end else begin
         chk_vld <= out_wrena;
         if (out_wrena) begin
            lane = out_adr[atl_pkg::LANE_W-1:0];
            chk_got      <= {out_dat, out_mty, out_adr, out_sop, out_eop, out_err};
            served[lane] <= 1'b1;
            if (out_sop) begin
               in_pkt  <= !out_eop;
               pkt_adr <= out_adr;
            end else if (out_eop) begin
               in_pkt <= 1'b0;
            end
            if (exp_q[lane].size() == 0) begin
               chk_empty <= 1'b1;                         // word nobody sent
            end else begin
               head = exp_q[lane].pop_front();
               chk_empty <= 1'b0;
               chk_exp   <= head[EXP_W-1:0];
               if (head[1] && head[EXP_W]) top_ends <= top_ends + 1;
               if (head[1] && !head[EXP_W]) bottom_ends <= bottom_ends + 1;
            end
         end
      end
   end

   // ---------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------
   a_idle_after_reset: assert property (@(posedge clk) disable iff (!reset_n)
      !traffic_started |-> !out_wrena && in_rdena)
      else stop_on_error($sformatf("** Error %0t ns: output active or sink stalled before traffic",
                                   $time));

   // covers data, mty, sop, eop, err and the top-only eop rule
   a_word_matches: assert property (@(posedge clk) disable iff (!reset_n)
      chk_vld |-> !chk_empty && chk_got == chk_exp)
      else stop_on_error($sformatf("** Error %0t ns: output word %h, expected %h, queue empty %b",
                                   $time, $sampled(chk_got), $sampled(chk_exp),
                                   $sampled(chk_empty)));

   a_pkt_starts_with_sop: assert property (@(posedge clk) disable iff (!reset_n)
      out_wrena && !in_pkt |-> out_sop)
      else stop_on_error($sformatf("** Error %0t ns: packet word outside sop..eop", $time));

   a_no_interleave: assert property (@(posedge clk) disable iff (!reset_n)
      out_wrena && in_pkt |-> !out_sop && out_adr == pkt_adr)
      else stop_on_error($sformatf("** Error %0t ns: address %h changed inside packet %h",
                                   $time, $sampled(out_adr), $sampled(pkt_adr)));

   a_strobe_after_rdena: assert property (@(posedge clk) disable iff (!reset_n)
      out_wrena |-> $past(out_rdena))
      else stop_on_error($sformatf("** Error %0t ns: out_wrena without out_rdena the cycle before",
                                   $time));

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// tb_clock_gen
// free running testbench clock, 40 ns period, with an active low
// reset held for the first 16 cycles
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic reset_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_NS     = 20;   // 40 ns period
   localparam int RESET_CYCLES = 16;

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_n <= 1'b1;                    // release on an edge, like the stimulus
   end

endmodule

`default_nettype wire

/* verilog/atl_conv2to1.sv */
// atl_conv2to1
// one lane's 2:1 width converter, each wide word leaves as top half
// then bottom half, a mostly empty last word leaves as top half only
`default_nettype none

module atl_conv2to1 (
   input  wire                          clk,
   input  wire                          reset_n,
   input  wire                          ai_rddav,
   output wire                          ai_rdena,
   input  wire                          ai_wrena,
   input  wire atl_pkg::wide_dat_t      ai_dat,
   input  wire atl_pkg::wide_mty_t      ai_mty,
   input  wire atl_pkg::adr_t           ai_adr,
   input  wire                          ai_sop,
   input  wire                          ai_eop,
   input  wire                          ai_err,
   output wire                          ao_rddav,
   input  wire                          ao_rdena,
   output logic                         ao_wrena,
   output atl_pkg::narrow_dat_t         ao_dat,
   output atl_pkg::narrow_mty_t         ao_mty,
   output atl_pkg::adr_t                ao_adr,
   output logic                         ao_sop,
   output logic                         ao_eop,
   output logic                         ao_err
);

   logic top_sent;      // top half out, bottom half owed
   logic just_popped;   // read request went out last cycle
   logic pend;          // word arrived while frozen
   logic in_vld;
   logic top_only;      // last word fits in the top half

   assign ao_rddav = ai_rddav;             // no latency on dav
   assign in_vld   = ai_wrena | pend;
   assign top_only = ai_eop & ai_mty[atl_pkg::WIDE_MTY_W-1];

   // no pop while a word is still being halved, nor past the packet end
   assign ai_rdena = ao_rdena & ~(just_popped & ai_wrena) & ~pend
                     & ~(top_sent & ai_eop);

   // ---------------------------------------------------------------------
   // control
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ao_wrena    <= 1'b0;
         top_sent    <= 1'b0;
         just_popped <= 1'b0;
         pend        <= 1'b0;
      end else begin
         just_popped <= ai_rdena;
         if (ao_rdena) begin
            pend <= 1'b0;
            if (!top_sent) begin
               ao_wrena <= in_vld;
               top_sent <= in_vld;
            end else begin
               ao_wrena <= ~top_only;      // eop already went with the top half
               top_sent <= 1'b0;
            end
         end else if (ai_wrena) begin
            pend <= 1'b1;                  // frozen, feeder holds the data
         end
      end
   end

   // ---------------------------------------------------------------------
   // payload halves
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (ao_rdena) begin
         if (!top_sent) begin
            if (in_vld) begin
               ao_dat <= ai_dat[atl_pkg::WIDE_W-1:atl_pkg::NARROW_W];
               ao_adr <= ai_adr;
               ao_sop <= ai_sop;
               ao_err <= ai_err;
               ao_eop <= top_only;
               // mty of 4..7 leaves 0..3 empty bytes in the top half
               ao_mty <= top_only ? ai_mty[atl_pkg::NARROW_MTY_W-1:0] : '0;
            end
         end else begin
            ao_dat <= ai_dat[atl_pkg::NARROW_W-1:0];
            ao_adr <= ai_adr;
            ao_sop <= 1'b0;                // bottom half never starts a packet
            ao_err <= ai_err;
            ao_eop <= ai_eop;
            ao_mty <= ai_mty[atl_pkg::NARROW_MTY_W-1:0];
         end
      end
   end

   a_bottom_no_sop: assert property (@(posedge clk) disable iff (!reset_n)
      ao_wrena && $past(top_sent && ao_rdena) |-> !ao_sop);

endmodule

`default_nettype wire

/* verilog/atl_ingress_buffer.sv */
// atl_ingress_buffer
// wide Atlantic sink, steers each word to a lane buffer by address,
// serves per-lane reads one cycle after the request
`default_nettype none

module atl_ingress_buffer (
   input  wire                                clk,
   input  wire                                reset_n,
   input  wire                                in_wrena,
   input  wire atl_pkg::wide_dat_t            in_dat,
   input  wire atl_pkg::wide_mty_t            in_mty,
   input  wire atl_pkg::adr_t                 in_adr,
   input  wire                                in_sop,
   input  wire                                in_eop,
   input  wire                                in_err,
   output wire                                in_rdena,
   input  wire [atl_pkg::NUM_LANES-1:0]       lane_rdena,
   output wire [atl_pkg::NUM_LANES-1:0]       lane_rddav,
   output wire [atl_pkg::NUM_LANES-1:0]       lane_wrena,
   output atl_pkg::wide_dat_t                 lane_dat [atl_pkg::NUM_LANES],
   output atl_pkg::wide_mty_t                 lane_mty [atl_pkg::NUM_LANES],
   output atl_pkg::adr_t                      lane_adr [atl_pkg::NUM_LANES],
   output wire [atl_pkg::NUM_LANES-1:0]       lane_sop,
   output wire [atl_pkg::NUM_LANES-1:0]       lane_eop,
   output wire [atl_pkg::NUM_LANES-1:0]       lane_err
);

   atl_pkg::lane_t                in_lane;   // lane of the incoming word
   logic [atl_pkg::NUM_LANES-1:0] room;      // lane has two or more free words

   assign in_lane  = in_adr[atl_pkg::LANE_W-1:0];
   assign in_rdena = &room;                  // one full lane stalls the sink

   for (genvar l = 0; l < atl_pkg::NUM_LANES; l++) begin : g_lane

      atl_pkg::wide_dat_t      mem_dat [atl_pkg::BUF_DEPTH];
      atl_pkg::wide_mty_t      mem_mty [atl_pkg::BUF_DEPTH];
      atl_pkg::adr_t           mem_adr [atl_pkg::BUF_DEPTH];
      logic [2:0]              mem_flg [atl_pkg::BUF_DEPTH];  // sop, eop, err
      atl_pkg::ptr_t           wr_ptr;
      atl_pkg::ptr_t           rd_ptr;
      logic [atl_pkg::PTR_W:0] word_cnt;     // stored words
      logic [atl_pkg::PTR_W:0] pkt_cnt;      // stored complete packets
      logic                    wr_hit;
      logic                    rd_hit;       // read request honoured
      logic                    rd_vld;
      logic [2:0]              flg_q;
      logic                    eop_gap;      // eop word was just presented

      assign wr_hit = in_wrena && (in_lane == atl_pkg::lane_t'(l));
      assign rd_hit = lane_rdena[l] && !eop_gap;    // packet end rule
      assign room[l] = word_cnt <= (atl_pkg::PTR_W + 1)'(atl_pkg::BUF_DEPTH - 2);
      assign lane_rddav[l] = pkt_cnt != '0;
      assign lane_wrena[l] = rd_vld;
      assign {lane_sop[l], lane_eop[l], lane_err[l]} = flg_q;

      // word storage
      always_ff @(posedge clk) begin
         if (wr_hit) begin
            mem_dat[wr_ptr] <= in_dat;
            mem_mty[wr_ptr] <= in_mty;
            mem_adr[wr_ptr] <= in_adr;
            mem_flg[wr_ptr] <= {in_sop, in_eop, in_err};
         end
      end

      // read data, held until the next honoured read
      always_ff @(posedge clk) begin
         if (rd_hit) begin
            lane_dat[l] <= mem_dat[rd_ptr];
            lane_mty[l] <= mem_mty[rd_ptr];
            lane_adr[l] <= mem_adr[rd_ptr];
            flg_q       <= mem_flg[rd_ptr];
         end
      end

      always_ff @(posedge clk or negedge reset_n) begin
         if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_cnt <= '0;
            pkt_cnt  <= '0;
            rd_vld   <= 1'b0;
            eop_gap  <= 1'b0;
         end else begin
            if (wr_hit) wr_ptr <= wr_ptr + 1'b1;
            if (rd_hit) rd_ptr <= rd_ptr + 1'b1;
            rd_vld  <= rd_hit;                      // strobe, one cycle
            eop_gap <= rd_vld && flg_q[1];

            case ({wr_hit, rd_hit})
               2'b10:   word_cnt <= word_cnt + 1'b1;
               2'b01:   word_cnt <= word_cnt - 1'b1;
               default: ;
            endcase

            // packet count moves on eop in and eop out
            case ({wr_hit && in_eop, rd_hit && mem_flg[rd_ptr][1]})
               2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
               2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
               default: ;
            endcase
         end
      end

      // sink must respect in_rdena
      a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
         wr_hit |-> word_cnt != (atl_pkg::PTR_W + 1)'(atl_pkg::BUF_DEPTH));

      // converter and merger only read inside a stored packet
      a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
         rd_hit |-> word_cnt != '0);

   end

endmodule

`default_nettype wire

/* verilog/atl_narrow_path.sv */
// atl_narrow_path
// 64 to 32 bit packet narrowing path, lane buffers feed one 2:1
// converter per lane, a round-robin merger drives the output
`default_nettype none

module atl_narrow_path (
   input  wire                       clk,
   input  wire                       reset_n,
   input  wire                       in_wrena,
   input  wire atl_pkg::wide_dat_t   in_dat,
   input  wire atl_pkg::wide_mty_t   in_mty,
   input  wire atl_pkg::adr_t        in_adr,
   input  wire                       in_sop,
   input  wire                       in_eop,
   input  wire                       in_err,
   output wire                       in_rdena,
   input  wire                       out_rdena,
   output wire                       out_wrena,
   output atl_pkg::narrow_dat_t      out_dat,
   output atl_pkg::narrow_mty_t      out_mty,
   output atl_pkg::adr_t             out_adr,
   output wire                       out_sop,
   output wire                       out_eop,
   output wire                       out_err
);

   // ---------------------------------------------------------------------
   // lane buffers to converters, wide side
   // ---------------------------------------------------------------------
   wire [atl_pkg::NUM_LANES-1:0] lane_rddav, lane_rdena, lane_wrena;
   wire [atl_pkg::NUM_LANES-1:0] lane_sop, lane_eop, lane_err;
   wire atl_pkg::wide_dat_t      lane_dat [atl_pkg::NUM_LANES];
   wire atl_pkg::wide_mty_t      lane_mty [atl_pkg::NUM_LANES];
   wire atl_pkg::adr_t           lane_adr [atl_pkg::NUM_LANES];

   // converters to merger, narrow side
   wire [atl_pkg::NUM_LANES-1:0] conv_rddav, conv_rdena, conv_wrena;
   wire [atl_pkg::NUM_LANES-1:0] conv_sop, conv_eop, conv_err;
   wire atl_pkg::narrow_dat_t    conv_dat [atl_pkg::NUM_LANES];
   wire atl_pkg::narrow_mty_t    conv_mty [atl_pkg::NUM_LANES];
   wire atl_pkg::adr_t           conv_adr [atl_pkg::NUM_LANES];

   atl_ingress_buffer u_ingress (
      .clk(clk), .reset_n(reset_n),
      .in_wrena(in_wrena), .in_dat(in_dat), .in_mty(in_mty), .in_adr(in_adr),
      .in_sop(in_sop), .in_eop(in_eop), .in_err(in_err), .in_rdena(in_rdena),
      .lane_rdena(lane_rdena), .lane_rddav(lane_rddav), .lane_wrena(lane_wrena),
      .lane_dat(lane_dat), .lane_mty(lane_mty), .lane_adr(lane_adr),
      .lane_sop(lane_sop), .lane_eop(lane_eop), .lane_err(lane_err)
   );

   for (genvar i = 0; i < atl_pkg::NUM_LANES; i++) begin : g_conv
      atl_conv2to1 u_conv (
         .clk(clk), .reset_n(reset_n),
         .ai_rddav(lane_rddav[i]), .ai_rdena(lane_rdena[i]), .ai_wrena(lane_wrena[i]),
         .ai_dat(lane_dat[i]), .ai_mty(lane_mty[i]), .ai_adr(lane_adr[i]),
         .ai_sop(lane_sop[i]), .ai_eop(lane_eop[i]), .ai_err(lane_err[i]),
         .ao_rddav(conv_rddav[i]), .ao_rdena(conv_rdena[i]), .ao_wrena(conv_wrena[i]),
         .ao_dat(conv_dat[i]), .ao_mty(conv_mty[i]), .ao_adr(conv_adr[i]),
         .ao_sop(conv_sop[i]), .ao_eop(conv_eop[i]), .ao_err(conv_err[i])
      );
   end

   atl_packet_merge u_merge (
      .clk(clk), .reset_n(reset_n),
      .conv_rddav(conv_rddav), .conv_rdena(conv_rdena), .conv_wrena(conv_wrena),
      .conv_dat(conv_dat), .conv_mty(conv_mty), .conv_adr(conv_adr),
      .conv_sop(conv_sop), .conv_eop(conv_eop), .conv_err(conv_err),
      .out_rdena(out_rdena), .out_wrena(out_wrena),
      .out_dat(out_dat), .out_mty(out_mty), .out_adr(out_adr),
      .out_sop(out_sop), .out_eop(out_eop), .out_err(out_err)
   );

endmodule

`default_nettype wire

/* verilog/atl_packet_merge.sv */
// atl_packet_merge
// round-robin packet arbiter over the lane converters, whole packets
// go one at a time onto the registered narrow output
`default_nettype none

module atl_packet_merge (
   input  wire                            clk,
   input  wire                            reset_n,
   input  wire [atl_pkg::NUM_LANES-1:0]   conv_rddav,
   output logic [atl_pkg::NUM_LANES-1:0]  conv_rdena,
   input  wire [atl_pkg::NUM_LANES-1:0]   conv_wrena,
   input  wire atl_pkg::narrow_dat_t      conv_dat [atl_pkg::NUM_LANES],
   input  wire atl_pkg::narrow_mty_t      conv_mty [atl_pkg::NUM_LANES],
   input  wire atl_pkg::adr_t             conv_adr [atl_pkg::NUM_LANES],
   input  wire [atl_pkg::NUM_LANES-1:0]   conv_sop,
   input  wire [atl_pkg::NUM_LANES-1:0]   conv_eop,
   input  wire [atl_pkg::NUM_LANES-1:0]   conv_err,
   input  wire                            out_rdena,
   output logic                           out_wrena,
   output atl_pkg::narrow_dat_t           out_dat,
   output atl_pkg::narrow_mty_t           out_mty,
   output atl_pkg::adr_t                  out_adr,
   output logic                           out_sop,
   output logic                           out_eop,
   output logic                           out_err
);

   logic [atl_pkg::NUM_LANES-1:0] grant;    // one-hot, zero while idle
   atl_pkg::lane_t                rr_ptr;   // lane granted last
   logic [atl_pkg::NUM_LANES-1:0] rdena_q;  // conv_rdena one cycle back
   logic                          hold;     // taken word waits for out_rdena
   atl_pkg::lane_t                nxt_lane;
   logic                          nxt_vld;
   logic                          take;     // fresh word from granted lane
   logic                          take_eop;

   // nearest lane after rr_ptr with a stored packet
   always_comb begin : pick
      atl_pkg::lane_t idx;
      nxt_vld  = 1'b0;
      nxt_lane = rr_ptr;
      for (int k = atl_pkg::NUM_LANES; k >= 1; k--) begin
         idx = rr_ptr + atl_pkg::lane_t'(k);
         if (conv_rddav[idx]) begin
            nxt_vld  = 1'b1;
            nxt_lane = idx;
         end
      end
   end

   // a word counts only if the converter was enabled to make it
   assign take     = (|grant) && conv_wrena[rr_ptr] && rdena_q[rr_ptr];
   assign take_eop = take && conv_eop[rr_ptr];

   // stop the lane as soon as its eop is taken
   assign conv_rdena = grant & {atl_pkg::NUM_LANES{out_rdena & ~hold & ~take_eop}};

   // ---------------------------------------------------------------------
   // grant and output strobe
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         grant     <= '0;
         rr_ptr    <= '0;
         rdena_q   <= '0;
         hold      <= 1'b0;
         out_wrena <= 1'b0;
      end else begin
         rdena_q   <= conv_rdena;
         out_wrena <= (take | hold) & out_rdena;   // only after sink said yes
         hold      <= (take | hold) & ~out_rdena;
         if (take_eop) begin
            grant <= '0;                            // packet done
         end else if (grant == '0 && nxt_vld) begin
            grant           <= '0;
            grant[nxt_lane] <= 1'b1;
            rr_ptr          <= nxt_lane;
         end
      end
   end

   // output word, loaded from the granted converter
   always_ff @(posedge clk) begin
      if (take) begin
         out_dat <= conv_dat[rr_ptr];
         out_mty <= conv_mty[rr_ptr];
         out_adr <= conv_adr[rr_ptr];
         out_sop <= conv_sop[rr_ptr];
         out_eop <= conv_eop[rr_ptr];
         out_err <= conv_err[rr_ptr];
      end
   end

   // one lane at most, and it is the one rr_ptr selects
   a_grant_onehot0: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(grant) && (grant == '0 || grant[rr_ptr]));

endmodule

`default_nettype wire

/* verilog/atl_pkg.sv */
// atl_pkg
// widths, sizes and vector types shared by the packet narrowing path
`default_nettype none

package atl_pkg;

   // ---------------------------------------------------------------------
   // bus widths
   // ---------------------------------------------------------------------
   localparam int WIDE_W       = 64;   // sink side data word
   localparam int NARROW_W     = 32;   // output data word
   localparam int WIDE_MTY_W   = 3;    // empty bytes in a wide word
   localparam int NARROW_MTY_W = 2;
   localparam int ADR_W        = 8;    // packet address

   // ---------------------------------------------------------------------
   // lanes and buffering
   // ---------------------------------------------------------------------
   localparam int NUM_LANES    = 4;
   localparam int LANE_W       = 2;    // lane = low address bits
   localparam int BUF_DEPTH    = 16;   // words per lane buffer
   localparam int PTR_W        = 4;

   typedef logic [WIDE_W-1:0]       wide_dat_t;
   typedef logic [NARROW_W-1:0]     narrow_dat_t;
   typedef logic [WIDE_MTY_W-1:0]   wide_mty_t;
   typedef logic [NARROW_MTY_W-1:0] narrow_mty_t;
   typedef logic [ADR_W-1:0]        adr_t;
   typedef logic [LANE_W-1:0]       lane_t;
   typedef logic [PTR_W-1:0]        ptr_t;

endpackage

`default_nettype wire
